/* cpu_cfg.svh */
// cpu configuration, datapath widths, instruction store depth and flag/device numbering
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath, program counter and instruction widths
`define CPU_DATA_W 8
`define CPU_PC_W 16
`define CPU_INSTR_W 48

// instruction store, only the low address bits of pc are decoded
`define CPU_ROM_DEPTH 256
`define CPU_ROM_AW 8

// general register bank and active-low target select lines
`define CPU_NUM_REGS 4
`define CPU_NUM_TDEV 16

// flag vector layout c z o n gt lt eq ne, c in the top bit
`define CPU_FLAG_W 8
`define CPU_FLAG_C 7
`define CPU_FLAG_Z 6
`define CPU_FLAG_O 5
`define CPU_FLAG_N 4
`define CPU_FLAG_GT 3
`define CPU_FLAG_LT 2
`define CPU_FLAG_EQ 1
`define CPU_FLAG_NE 0

`endif

/* cpu_pkg.sv */
// cpu types, encodings for alu opcodes, conditions and bus/target devices
package cpu_pkg;

    // alu opcodes, instruction byte 6 bits 7..3
    // unlisted codes give a zero result
    typedef enum logic [4:0] {
        op_pass_a = 5'd0,
        op_pass_b = 5'd1,
        op_add    = 5'd2,
        op_sub    = 5'd3,
        op_and    = 5'd4,
        op_or     = 5'd5,
        op_xor    = 5'd6,
        op_not_a  = 5'd7,
        op_shl    = 5'd8,
        op_shr    = 5'd9,
        op_inc_a  = 5'd10,
        op_dec_a  = 5'd11
    } alu_op_e;

    // condition codes, 10 and up never execute
    typedef enum logic [3:0] {
        cond_always = 4'd0,
        cond_c      = 4'd1,
        cond_z      = 4'd2,
        cond_o      = 4'd3,
        cond_n      = 4'd4,
        cond_gt     = 4'd5,
        cond_lt     = 4'd6,
        cond_eq     = 4'd7,
        cond_ne     = 4'd8,
        cond_di     = 4'd9,
        cond_never  = 4'd10
    } cond_e;

    // a-bus source devices
    typedef enum logic [2:0] {
        dev_ra      = 3'd0,
        dev_rb      = 3'd1,
        dev_rc      = 3'd2,
        dev_rd      = 3'd3,
        dev_immed   = 3'd4,
        dev_addr_lo = 3'd5,
        dev_addr_hi = 3'd6,
        dev_zero    = 3'd7
    } adev_e;

    // b-bus uses the same numbering
    typedef adev_e bdev_e;

    // target devices, 6..15 select nothing
    typedef enum logic [3:0] {
        tdev_ra       = 4'd0,
        tdev_rb       = 4'd1,
        tdev_rc       = 4'd2,
        tdev_rd       = 4'd3,
        tdev_pc_jump  = 4'd4,
        tdev_port_out = 4'd5,
        tdev_nop      = 4'd6
    } tdev_e;

endpackage

/* instr_rom.sv */
// instruction store, one 48-bit word per address, loadable, read combinationally at pc
`include "cpu_cfg.svh"

module instr_rom (
    input  logic                    clk,
    input  logic                    prog_we,
    input  logic [`CPU_ROM_AW-1:0]  prog_addr,
    input  logic [`CPU_INSTR_W-1:0] prog_data,
    input  logic [`CPU_PC_W-1:0]    pc,
    output logic [`CPU_INSTR_W-1:0] instr
);

    // one wide word holds all six instruction bytes
    logic [`CPU_INSTR_W-1:0] mem [`CPU_ROM_DEPTH];

    // pc wraps modulo the depth
    logic [`CPU_ROM_AW-1:0] rd_addr;

    assign rd_addr = pc[`CPU_ROM_AW-1:0];

    // program load port
    // only used while the core is stopped
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // asynchronous fetch
    assign instr = mem[rd_addr];

endmodule

/* controller.sv */
// instruction decoder, slices fields, evaluates the condition and drives active-low target selects
`include "cpu_cfg.svh"

module controller (
    input  logic [`CPU_INSTR_W-1:0]  instr,
    input  logic [`CPU_FLAG_W-1:0]   flags,
    input  logic                     data_in_ready,
    output cpu_pkg::alu_op_e         alu_op,
    output cpu_pkg::adev_e           adev,
    output cpu_pkg::bdev_e           bdev,
    output logic [`CPU_DATA_W-1:0]   immed,
    output logic [`CPU_DATA_W-1:0]   addr_lo,
    output logic [`CPU_DATA_W-1:0]   addr_hi,
    output logic                     set_flags_n,
    output logic [`CPU_NUM_TDEV-1:0] tsel_n
);

    cpu_pkg::tdev_e targ;
    cpu_pkg::cond_e cond;
    logic           do_exec;

    // byte 6 top five bits
    assign alu_op = cpu_pkg::alu_op_e'(instr[47:43]);

    // target straddles bytes 6 and 5
    assign targ = cpu_pkg::tdev_e'({instr[42:40], instr[39]});

    // bus sources in byte 5
    assign adev = cpu_pkg::adev_e'(instr[38:36]);
    assign bdev = cpu_pkg::bdev_e'(instr[35:33]);

    // condition straddles bytes 5 and 4
    assign cond = cpu_pkg::cond_e'({instr[32], instr[31:29]});

    // flag load strobe, low loads
    // byte 4 bit 0 is the reserved address-mode bit
    assign set_flags_n = instr[28];

    // direct address and immediate bytes
    assign addr_hi = instr[23:16];
    assign addr_lo = instr[15:8];
    assign immed   = instr[7:0];

    // flag select for the condition
    always_comb begin
        case (cond)
            cpu_pkg::cond_always: do_exec = 1'b1;
            cpu_pkg::cond_c:      do_exec = flags[`CPU_FLAG_C];
            cpu_pkg::cond_z:      do_exec = flags[`CPU_FLAG_Z];
            cpu_pkg::cond_o:      do_exec = flags[`CPU_FLAG_O];
            cpu_pkg::cond_n:      do_exec = flags[`CPU_FLAG_N];
            cpu_pkg::cond_gt:     do_exec = flags[`CPU_FLAG_GT];
            cpu_pkg::cond_lt:     do_exec = flags[`CPU_FLAG_LT];
            cpu_pkg::cond_eq:     do_exec = flags[`CPU_FLAG_EQ];
            cpu_pkg::cond_ne:     do_exec = flags[`CPU_FLAG_NE];
            // external level, not a flag
            cpu_pkg::cond_di:     do_exec = data_in_ready;
            // cond_never and codes above it
            default:              do_exec = 1'b0;
        endcase
    end

    // 4-to-16 demux, active low
    // a false condition keeps every line high
    always_comb begin
        tsel_n = '1;
        if (do_exec) begin
            tsel_n[targ] = 1'b0;
        end
    end

endmodule

/* alu.sv */
// alu, combinational result per opcode plus the c z o n gt lt eq ne flag register
`include "cpu_cfg.svh"

module alu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  cpu_pkg::alu_op_e       op,
    input  logic [`CPU_DATA_W-1:0] a_bus,
    input  logic [`CPU_DATA_W-1:0] b_bus,
    input  logic                   set_flags_n,
    output logic [`CPU_DATA_W-1:0] result,
    output logic [`CPU_FLAG_W-1:0] flags
);

    // one spare bit on top for carry/borrow
    logic [`CPU_DATA_W:0]   wide;
    logic                   carry;
    logic                   ovf;
    logic [`CPU_FLAG_W-1:0] flags_d;

    always_comb begin
        wide  = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            cpu_pkg::op_pass_a: wide = {1'b0, a_bus};
            cpu_pkg::op_pass_b: wide = {1'b0, b_bus};
            cpu_pkg::op_add: begin
                wide  = {1'b0, a_bus} + {1'b0, b_bus};
                carry = wide[`CPU_DATA_W];
                // same-sign operands, sign flipped
                ovf   = (a_bus[`CPU_DATA_W-1] == b_bus[`CPU_DATA_W-1]) &&
                        (wide[`CPU_DATA_W-1] != a_bus[`CPU_DATA_W-1]);
            end
            cpu_pkg::op_sub: begin
                // top bit is the borrow
                wide  = {1'b0, a_bus} - {1'b0, b_bus};
                carry = wide[`CPU_DATA_W];
                ovf   = (a_bus[`CPU_DATA_W-1] != b_bus[`CPU_DATA_W-1]) &&
                        (wide[`CPU_DATA_W-1] != a_bus[`CPU_DATA_W-1]);
            end
            cpu_pkg::op_and:   wide = {1'b0, a_bus & b_bus};
            cpu_pkg::op_or:    wide = {1'b0, a_bus | b_bus};
            cpu_pkg::op_xor:   wide = {1'b0, a_bus ^ b_bus};
            cpu_pkg::op_not_a: wide = {1'b0, ~a_bus};
            cpu_pkg::op_shl: begin
                // msb falls out into carry
                wide  = {a_bus, 1'b0};
                carry = a_bus[`CPU_DATA_W-1];
            end
            cpu_pkg::op_shr: begin
                wide  = {2'b00, a_bus[`CPU_DATA_W-1:1]};
                carry = a_bus[0];
            end
            cpu_pkg::op_inc_a: wide = {1'b0, a_bus} + 1'b1;
            cpu_pkg::op_dec_a: wide = {1'b0, a_bus} - 1'b1;
            default:           wide = '0;
        endcase
    end

    assign result = wide[`CPU_DATA_W-1:0];

    // next flag values, compares are unsigned on the raw buses
    always_comb begin
        flags_d              = '0;
        flags_d[`CPU_FLAG_C]  = carry;
        flags_d[`CPU_FLAG_Z]  = (result == '0);
        flags_d[`CPU_FLAG_O]  = ovf;
        flags_d[`CPU_FLAG_N]  = result[`CPU_DATA_W-1];
        flags_d[`CPU_FLAG_GT] = (a_bus > b_bus);
        flags_d[`CPU_FLAG_LT] = (a_bus < b_bus);
        flags_d[`CPU_FLAG_EQ] = (a_bus == b_bus);
        flags_d[`CPU_FLAG_NE] = (a_bus != b_bus);
    end

    // loads regardless of the condition outcome
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (run && !set_flags_n) begin
            flags <= flags_d;
        end
    end

endmodule

/* reg_file.sv */
// general register bank, four 8-bit registers with a/b bus source muxes and write-back
`include "cpu_cfg.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  cpu_pkg::adev_e           adev,
    input  cpu_pkg::bdev_e           bdev,
    input  logic [`CPU_DATA_W-1:0]   immed,
    input  logic [`CPU_DATA_W-1:0]   addr_lo,
    input  logic [`CPU_DATA_W-1:0]   addr_hi,
    input  logic [`CPU_DATA_W-1:0]   result,
    input  logic [`CPU_NUM_REGS-1:0] tsel_n,
    output logic [`CPU_DATA_W-1:0]   a_bus,
    output logic [`CPU_DATA_W-1:0]   b_bus
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

    // shared source decode for both buses
    function automatic logic [`CPU_DATA_W-1:0] src_sel(input cpu_pkg::adev_e dev);
        logic [`CPU_DATA_W-1:0] v;
        case (dev)
            cpu_pkg::dev_ra:      v = regs[0];
            cpu_pkg::dev_rb:      v = regs[1];
            cpu_pkg::dev_rc:      v = regs[2];
            cpu_pkg::dev_rd:      v = regs[3];
            cpu_pkg::dev_immed:   v = immed;
            cpu_pkg::dev_addr_lo: v = addr_lo;
            cpu_pkg::dev_addr_hi: v = addr_hi;
            default:              v = '0;
        endcase
        return v;
    endfunction

    always_comb begin
        a_bus = src_sel(adev);
        b_bus = src_sel(bdev);
    end

    // write-back, select lines are already condition gated
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (run) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                if (!tsel_n[i]) begin
                    regs[i] <= result;
                end
            end
        end
    end

endmodule

/* pc_unit.sv */
// program counter, increments each step or loads an absolute jump target
`include "cpu_cfg.svh"

module pc_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  logic                 jump_n,
    input  logic [`CPU_PC_W-1:0] jump_addr,
    output logic [`CPU_PC_W-1:0] pc
);

    logic [`CPU_PC_W-1:0] pc_next;

    // jump select is low only when the condition passed
    assign pc_next = jump_n ? pc + 1'b1 : jump_addr;

    // frozen while stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

endmodule

/* cpu_core.sv */
// cpu top, instruction store, decoder, datapath, program counter and output port register
`include "cpu_cfg.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  logic                    data_in_ready,
    input  logic                    prog_we,
    input  logic [`CPU_ROM_AW-1:0]  prog_addr,
    input  logic [`CPU_INSTR_W-1:0] prog_data,
    output logic [`CPU_PC_W-1:0]    pc,
    output logic [`CPU_DATA_W-1:0]  out_data,
    output logic                    out_valid
);

    logic [`CPU_INSTR_W-1:0]  instr;
    logic [`CPU_FLAG_W-1:0]   flags;
    cpu_pkg::alu_op_e         alu_op;
    cpu_pkg::adev_e           adev;
    cpu_pkg::bdev_e           bdev;
    logic [`CPU_DATA_W-1:0]   immed;
    logic [`CPU_DATA_W-1:0]   addr_lo;
    logic [`CPU_DATA_W-1:0]   addr_hi;
    logic                     set_flags_n;
    logic [`CPU_NUM_TDEV-1:0] tsel_n;
    logic [`CPU_DATA_W-1:0]   a_bus;
    logic [`CPU_DATA_W-1:0]   b_bus;
    logic [`CPU_DATA_W-1:0]   result;
    logic                     port_wr_q;

    instr_rom u_rom (.clk, .prog_we, .prog_addr, .prog_data, .pc, .instr);

    controller u_ctrl (.instr, .flags, .data_in_ready, .alu_op, .adev, .bdev, .immed,
                       .addr_lo, .addr_hi, .set_flags_n, .tsel_n);

    alu u_alu (.clk, .rst_n, .run, .op(alu_op), .a_bus, .b_bus, .set_flags_n, .result,
               .flags);

    // only the register selects reach the bank
    reg_file u_regs (.clk, .rst_n, .run, .adev, .bdev, .immed, .addr_lo, .addr_hi, .result,
                     .tsel_n(tsel_n[`CPU_NUM_REGS-1:0]), .a_bus, .b_bus);

    pc_unit u_pc (.clk, .rst_n, .run, .jump_n(tsel_n[cpu_pkg::tdev_pc_jump]),
                  .jump_addr({addr_hi, addr_lo}), .pc);

    // output port register
    // data held until the next port write
    // strobe state holds while stopped and is shown again once run returns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_wr_q <= 1'b0;
            out_data  <= '0;
        end else if (run) begin
            port_wr_q <= !tsel_n[cpu_pkg::tdev_port_out];
            if (!tsel_n[cpu_pkg::tdev_port_out]) begin
                out_data <= result;
            end
        end
    end

    // no pulse while stopped
    assign out_valid = port_wr_q && run;

endmodule

/* cpu_core_props.sv */
// cpu core properties, output strobe, target select and program counter checks
`include "cpu_cfg.svh"

module cpu_core_props (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     run,
    input logic [`CPU_PC_W-1:0]     pc,
    input logic                     out_valid,
    input logic [`CPU_NUM_TDEV-1:0] tsel_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // strobe clear once reset lifts
    assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("out_valid high right after reset");

    // stopped core never strobes
    assert property (@(posedge clk) disable iff (!rst_n) !run |-> !out_valid)
        else $error("out_valid high while run is low");

    // at most one target device selected
    assert property (@(posedge clk) disable iff (!rst_n) run |-> $onehot0(~tsel_n))
        else $error("more than one tsel_n line low");

    // pc frozen while stopped
    assert property (@(posedge clk) disable iff (!rst_n) !run |=> $stable(pc))
        else $error("pc moved while run is low");

endmodule

bind cpu_core cpu_core_props u_props (.clk, .rst_n, .run, .pc, .out_valid, .tsel_n);

/* tb_cpu_core.sv */
// cpu core testbench, loads the program from the vector file and checks port output values
`include "cpu_cfg.svh"

module tb_cpu_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic                    clk;
    logic                    rst_n;
    logic                    run;
    logic                    data_in_ready;
    logic                    prog_we;
    logic [`CPU_ROM_AW-1:0]  prog_addr;
    logic [`CPU_INSTR_W-1:0] prog_data;
    logic [`CPU_PC_W-1:0]    pc;
    logic [`CPU_DATA_W-1:0]  out_data;
    logic                    out_valid;

    // collected port writes, in order
    logic [`CPU_DATA_W-1:0]  got_q[$];
    int                      mismatches;
    int                      timeouts;
    int                      seed;

    cpu_core DUT (.clk, .rst_n, .run, .data_in_ready, .prog_we, .prog_addr, .prog_data,
                  .pc, .out_data, .out_valid);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every strobe seen on a rising edge is queued
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            got_q.push_back(out_data);
        end
    end

    // hard limit on the whole run
    initial begin
        #100us;
        $display("timeout: simulation did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic load_word(input logic [7:0] addr, input logic [47:0] word);
        @(posedge clk);
        prog_we       <= 1'b1;
        prog_addr     <= addr;
        prog_data     <= word;
        // idle level, core is stopped
        data_in_ready <= 1'($random(seed));
        @(posedge clk);
        prog_we       <= 1'b0;
    endtask

    // one instruction per edge while run is high
    task automatic run_cycles(input int n);
        @(posedge clk);
        run <= 1'b1;
        repeat (n) @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic expect_output(input logic [7:0] exp);
        int waited;
        logic [7:0] got;
        waited = 0;
        while (got_q.size() == 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (got_q.size() == 0) begin
            $display("timeout: no port output arrived for expected value 0x%0h", exp);
            timeouts++;
        end else begin
            got = got_q.pop_front();
            compare_value("out_data", 32'(got), 32'(exp));
        end
    endtask

    initial begin
        int fd;
        int rc;
        string tok;
        string line;
        logic [7:0] addr;
        logic [47:0] word;
        int n;

        seed          = 18;
        mismatches    = 0;
        timeouts      = 0;
        rst_n         = 1'b0;
        run           = 1'b0;
        data_in_ready = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // pc starts at zero out of reset
        @(posedge clk);
        compare_value("pc", 32'(pc), 32'h0);

        fd = $fopen("cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            timeouts++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fscanf(fd, "%s", tok);
                if (rc != 1) begin
                    break;
                end
                if (tok == "#") begin
                    // rest of a comment line
                    rc = $fgets(line, fd);
                end else if (tok == "P") begin
                    rc = $fscanf(fd, "%h %h", addr, word);
                    load_word(addr, word);
                end else if (tok == "D") begin
                    rc = $fscanf(fd, "%d", n);
                    @(posedge clk);
                    data_in_ready <= (n != 0);
                end else if (tok == "R") begin
                    rc = $fscanf(fd, "%d", n);
                    run_cycles(n);
                end else if (tok == "E") begin
                    rc = $fscanf(fd, "%h", addr);
                    expect_output(addr);
                end else begin
                    $display("unknown record type in the vector file");
                    timeouts++;
                end
            end
            $fclose(fd);
        end

        // nothing left over
        repeat (4) @(posedge clk);
        if (got_q.size() != 0) begin
            $display("unexpected port output, %0d extra values", got_q.size());
            mismatches++;
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* cpu_vectors.txt */
# records: P addr word (load program word), D level (data_in_ready), R n (run n cycles)
# E value (next expected out_data), all numbers in hex except R counts
P 00 004E1000005A
P 01 028E10000000
P 02 00CE10000037
P 03 128200000000
P 04 1A8210000000
P 05 328210000000
P 06 428EB0000000
P 07 5A8E90000000
P 08 FA8E70000000
P 09 1B0000000000
P 0A 02CE50000011
P 0B 02CF10000022
P 0C 1299400000D0
P 0D 02CE30000033
P 0E 02CED0000044
P 0F 027E30001100
P 10 02CE10000055
P 11 027E50001300
P 12 02CE10000066
P 13 02CF30000077
P 14 027E10001300
D 0
R 18
D 0
R 6
D 1
R 4
E 5A
E 91
E 23
E 6D
E B4
E 59
E 00
E 11
E 33
E 44
E 66
E 77
E 77

/* filelist.f */
+incdir+.
cpu_pkg.sv
instr_rom.sv
controller.sv
alu.sv
reg_file.sv
pc_unit.sv
cpu_core.sv
cpu_core_props.sv
tb_cpu_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
